// ==== project.f ====
+incdir+verif
common/cmpPkg.sv
cmp/fpCompare.sv
cmp/intCompare.sv
cmp/cmpUnit.sv
rtl/cmpExecute.sv
rtl/cmpTop.sv
verif/cmpTb.sv

// ==== Bender.yml ====
package:
  name: cmp_unit

sources:
  - common/cmpPkg.sv
  - cmp/fpCompare.sv
  - cmp/intCompare.sv
  - cmp/cmpUnit.sv
  - rtl/cmpExecute.sv
  - rtl/cmpTop.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/cmpTb.sv

// ==== verif/cmpModel.svh ====
// Compare unit reference model
// Expected condition vectors for 64-bit operands, with its own double decoding
`ifndef CMP_MODEL_SVH
`define CMP_MODEL_SVH

// A double is NaN when the exponent is all ones and the mantissa is not zero
function automatic logic isNan(input logic [63:0] v);
	return (v[62:52] == 11'h7ff) && (v[51:0] != 52'd0);
endfunction

// Maps a double onto a signed integer that has the same order
// Both zeros land on 0, so +0 and -0 compare equal
function automatic logic signed [64:0] orderKey(input logic [63:0] v);
	logic signed [64:0] mag;
	mag = {2'b00, v[62:0]};
	return v[63] ? -mag : mag;
endfunction

// ============================================================================
// Expected condition vector for one instruction
// ============================================================================

function automatic logic [63:0] refCompare(input instr_t ins, input logic [63:0] opA,
	input logic [63:0] opB, input logic [63:0] opImm);
	logic [63:0]        r;
	logic [63:0]        sec;
	logic               unord;
	logic               eq;
	logic               lt;
	logic               gt;
	logic signed [64:0] keyA;
	logic signed [64:0] keyB;
	r = '0;
	// Immediate forms take imm as the second operand, register forms take b
	sec = (ins.opcode == OP_CMPI || ins.opcode == OP_CMPUI) ? opImm : opB;
	if ((ins.opcode == OP_R3 && ins.func == FN_CMP) || ins.opcode == OP_CMPI)
	begin
		r[CB_EQ] = opA == sec;
		r[CB_NE] = opA != sec;
		r[CB_LT] = $signed(opA) < $signed(sec);
		r[CB_LE] = $signed(opA) <= $signed(sec);
		r[CB_GE] = $signed(opA) >= $signed(sec);
		r[CB_GT] = $signed(opA) > $signed(sec);
		// Bit index is the low six bits of the second operand
		r[CB_BS] = opA[sec[5:0]];
		r[CB_BC] = !opA[sec[5:0]];
	end
	else if ((ins.opcode == OP_R3 && ins.func == FN_CMPU) || ins.opcode == OP_CMPUI)
	begin
		r[CB_LT] = opA < sec;
		r[CB_LE] = opA <= sec;
		r[CB_GE] = opA >= sec;
		r[CB_GT] = opA > sec;
	end
	else if (ins.opcode == OP_FLT3 && ins.func == FN_FCMP)
	begin
		unord = isNan(opA) || isNan(opB);
		keyA  = orderKey(opA);
		keyB  = orderKey(opB);
		eq    = !unord && (keyA == keyB);
		lt    = !unord && (keyA < keyB);
		gt    = !unord && (keyA > keyB);
		r[FB_EQ]    = eq;
		r[FB_NE]    = !eq;
		r[FB_LT]    = lt;
		r[FB_LTU]   = unord || lt;
		r[FB_LE]    = lt || eq;
		r[FB_LEU]   = unord || lt || eq;
		r[FB_GT]    = gt;
		r[FB_GTU]   = unord || gt;
		r[FB_GE]    = gt || eq;
		r[FB_GEU]   = unord || gt || eq;
		r[FB_OGL]   = !unord && !eq;
		r[FB_UGL]   = unord || !eq;
		r[FB_ORD]   = !unord;
		r[FB_UNORD] = unord;
	end
	return r;
endfunction

`endif

// ==== verif/cmpTb.sv ====
// Compare execution unit testbench
// Random integer, immediate and float compares checked against a reference model
`timescale 1ns/1ps
`default_nettype none

module cmpTb
	import cmpPkg::*;
();

	localparam int WID = 64;

	// One expected completion, with the cycle on which done must show it
	typedef struct packed {
		tag_t           tag;
		logic [WID-1:0] vec;
		int             due;
	} expect_t;

	logic           clk;
	logic           rstN;
	logic           issue;
	cmpReq_t        req;
	logic [WID-1:0] a;
	logic [WID-1:0] b;
	logic [WID-1:0] imm;
	logic           done;
	tag_t           doneTag;
	logic [WID-1:0] result;

	integer  seed;
	int      cycle;
	tag_t    nextTag;
	logic    doneSeen;
	expect_t head;
	expect_t expQ[$];

	`include "cmpModel.svh"

	cmpTop #(.WID(WID)) UUT (
		.clk     (clk),
		.rstN    (rstN),
		.issue   (issue),
		.req     (req),
		.a       (a),
		.b       (b),
		.imm     (imm),
		.done    (done),
		.doneTag (doneTag),
		.result  (result)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Counts rising edges so that latency can be checked
	initial
		cycle = 0;
	always @(posedge clk)
		cycle <= cycle + 1;

	// ========================================================================
	// Failure reporting and compare tasks
	// ========================================================================

	task automatic failRun(input string why);
		$display("%s", why);
		$display("TESTBENCH FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic checkResult(input logic [WID-1:0] got, input logic [WID-1:0] exp);
		if (got !== exp)
			failRun($sformatf("MISMATCH at %0t: result %h, expected %h", $time, got, exp));
	endtask

	task automatic checkTag(input tag_t got, input tag_t exp);
		if (got !== exp)
			failRun($sformatf("MISMATCH at %0t: doneTag %0d, expected %0d", $time, got, exp));
	endtask

	// Outputs change on the rising edge, so the falling edge sees them settled
	initial
		doneSeen = 1'b0;
	always @(negedge clk)
	begin
		if (done)
		begin
			if (expQ.size() == 0)
				failRun("done went high while no operation was outstanding");
			head = expQ.pop_front();
			if (cycle != head.due)
				failRun($sformatf("done for tag %0d came on the wrong cycle", head.tag));
			checkTag(doneTag, head.tag);
			checkResult(result, head.vec);
			doneSeen = 1'b1;
		end
		else if (expQ.size() != 0 && cycle >= expQ[0].due)
			failRun("timed out waiting for done on an issued operation");
		else if (!doneSeen)
		begin
			checkResult(result, '0);
			checkTag(doneTag, '0);
		end
	end

	// ========================================================================
	// Stimulus helpers
	// ========================================================================

	function automatic logic [WID-1:0] pickInt();
		case ($unsigned($random(seed)) % 7)
			0: return '0;
			1: return {1'b1, {(WID-1){1'b0}}};
			2: return {1'b0, {(WID-1){1'b1}}};
			3: return '1;
			4: return 64'd1;
			default: return {$random(seed), $random(seed)};
		endcase
	endfunction

	// Special doubles show up often next to plain random bit patterns
	function automatic logic [WID-1:0] pickDouble();
		case ($unsigned($random(seed)) % 12)
			0: return 64'h0000_0000_0000_0000;
			1: return 64'h8000_0000_0000_0000;
			2: return 64'h7ff0_0000_0000_0000;
			3: return 64'hfff0_0000_0000_0000;
			4: return 64'h7ff8_0000_0000_0000;
			5: return 64'h7ff0_0000_0000_0001;
			6: return 64'h3ff0_0000_0000_0000;
			7: return 64'hc000_0000_0000_0000;
			default: return {$random(seed), $random(seed)};
		endcase
	endfunction

	function automatic instr_t makeInstr(input opcode_t op, input func_t fn);
		instr_t ins;
		ins.opcode = op;
		ins.func   = fn;
		ins.rsvd   = 21'($random(seed));
		return ins;
	endfunction

	// Mostly back to back, sometimes one or two idle cycles
	function automatic int gapLen();
		if (($unsigned($random(seed)) % 8) < 5)
			return 0;
		return 1 + ($unsigned($random(seed)) % 2);
	endfunction

	task automatic issueOp(input instr_t ins, input logic [WID-1:0] opA,
		input logic [WID-1:0] opB, input logic [WID-1:0] opImm);
		expect_t e;
		@(negedge clk);
		issue = 1'b1;
		req   = '{instr: ins, tag: nextTag};
		a     = opA;
		b     = opB;
		imm   = opImm;
		e.tag = nextTag;
		e.vec = refCompare(ins, opA, opB, opImm);
		// Done follows the second rising edge after this falling edge
		e.due = cycle + 2;
		expQ.push_back(e);
		nextTag = nextTag + 1'b1;
	endtask

	// Idle cycles carry junk operands that the pipeline must ignore
	task automatic idle(input int n);
		repeat (n)
		begin
			@(negedge clk);
			issue = 1'b0;
			a     = {$random(seed), $random(seed)};
			b     = {$random(seed), $random(seed)};
		end
	endtask

	// ========================================================================
	// Test sequence
	// ========================================================================

	initial
	begin
		logic [WID-1:0] opA;
		logic [WID-1:0] opB;
		int             waitCount;
		seed    = 32'h47be349c;
		nextTag = '0;
		rstN    = 1'b0;
		issue   = 1'b0;
		req     = '0;
		a       = '0;
		b       = '0;
		imm     = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
		idle(4);

		// Register compares, signed and unsigned, with some equal pairs
		repeat (200)
		begin
			opA = pickInt();
			opB = (($random(seed) & 3) == 0) ? opA : pickInt();
			issueOp(makeInstr(OP_R3, ($random(seed) & 1) ? FN_CMP : FN_CMPU), opA, opB, '0);
			idle(gapLen());
		end

		// Immediate compares with b random so that using it would show
		repeat (150)
		begin
			opA = pickInt();
			opB = (($random(seed) & 3) == 0) ? opA : pickInt();
			issueOp(makeInstr(($random(seed) & 1) ? OP_CMPI : OP_CMPUI, FN_ADD), opA,
				{$random(seed), $random(seed)}, opB);
			idle(gapLen());
		end

		// Float compares over specials, random doubles and equal pairs
		repeat (250)
		begin
			opA = pickDouble();
			opB = (($random(seed) & 7) == 0) ? opA : pickDouble();
			issueOp(makeInstr(OP_FLT3, FN_FCMP), opA, opB, pickInt());
			idle(gapLen());
		end

		// Opcodes and function codes that the unit does not handle
		issueOp(makeInstr(OP_ADDI, FN_CMP), pickInt(), pickInt(), pickInt());
		issueOp(makeInstr(OP_NOP, FN_FCMP), pickInt(), pickInt(), pickInt());
		issueOp(makeInstr(OP_BRK, FN_CMPU), pickInt(), pickInt(), pickInt());
		issueOp(makeInstr(OP_R3, FN_ADD), pickInt(), pickInt(), pickInt());
		issueOp(makeInstr(OP_R3, FN_FCMP), pickInt(), pickInt(), pickInt());
		issueOp(makeInstr(OP_FLT3, FN_CMP), pickInt(), pickInt(), pickInt());
		issueOp(makeInstr(opcode_t'(7'd50), FN_CMP), pickInt(), pickInt(), pickInt());
		idle(1);

		waitCount = 0;
		while (expQ.size() != 0)
		begin
			@(posedge clk);
			waitCount++;
			if (waitCount > 20)
				failRun("timed out waiting for the outstanding results to drain");
		end
		// A few quiet cycles catch a stray done
		repeat (3) @(posedge clk);
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== rtl/cmpTop.sv ====
// Compare execution unit top level
// Sets the operand width and brings the pipeline out to the pins
`timescale 1ns/1ps
`default_nettype none

module cmpTop
	import cmpPkg::*;
#(
	parameter int WID = 64
)
(
	input  wire logic           clk,
	input  wire logic           rstN,
	input  wire logic           issue,
	input  cmpReq_t             req,
	input  wire logic [WID-1:0] a,
	input  wire logic [WID-1:0] b,
	input  wire logic [WID-1:0] imm,
	output logic                done,
	output tag_t                doneTag,
	output logic [WID-1:0]      result
);

	// WID also picks the float format, so 16, 32, 64 and 128 are the legal values
	cmpExecute #(.WID(WID)) uExec (
		.clk     (clk),
		.rstN    (rstN),
		.issue   (issue),
		.req     (req),
		.a       (a),
		.b       (b),
		.imm     (imm),
		.done    (done),
		.doneTag (doneTag),
		.result  (result)
	);

endmodule

`default_nettype wire

// ==== rtl/cmpExecute.sv ====
// Compare execute pipeline
// Operand stage and result stage around the combinational compare unit
`timescale 1ns/1ps
`default_nettype none

module cmpExecute
	import cmpPkg::*;
#(
	parameter int WID = 64
)
(
	input  wire logic           clk,
	input  wire logic           rstN,
	input  wire logic           issue,
	input  cmpReq_t             req,
	input  wire logic [WID-1:0] a,
	input  wire logic [WID-1:0] b,
	input  wire logic [WID-1:0] imm,
	output logic                done,
	output tag_t                doneTag,
	output logic [WID-1:0]      result
);

	// Everything the compare unit needs for one operation
	typedef struct packed {
		cmpReq_t        req;
		logic [WID-1:0] a;
		logic [WID-1:0] b;
		logic [WID-1:0] imm;
	} opStage_t;

	opStage_t       s1;
	logic           s1Valid;
	logic [WID-1:0] unitResult;
	logic           s2Valid;

	// ========================================================================
	// Stage 1 operand capture
	// ========================================================================

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			s1Valid <= 1'b0;
		else
			s1Valid <= issue;
	end

	always_ff @(posedge clk)
	begin
		if (issue)
			s1 <= '{req: req, a: a, b: b, imm: imm};
	end

	cmpUnit #(.WID(WID)) uUnit (
		.instr  (s1.req.instr),
		.a      (s1.a),
		.b      (s1.b),
		.imm    (s1.imm),
		.result (unitResult)
	);

	// Stage 2 keeps the last result and tag until the next operation lands
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			s2Valid <= 1'b0;
			result  <= '0;
			doneTag <= '0;
		end
		else
		begin
			s2Valid <= s1Valid;
			if (s1Valid)
			begin
				result  <= unitResult;
				doneTag <= s1.req.tag;
			end
		end
	end

	assign done = s2Valid;

endmodule

`default_nettype wire

// ==== cmp/cmpUnit.sv ====
// Compare unit
// Decodes a compare instruction and forms the WID-bit condition vector
`timescale 1ns/1ps
`default_nettype none

module cmpUnit
	import cmpPkg::*;
#(
	parameter int WID = 64
)
(
	input  instr_t              instr,
	input  wire logic [WID-1:0] a,
	input  wire logic [WID-1:0] b,
	input  wire logic [WID-1:0] imm,
	output logic [WID-1:0]      result
);

	logic           useImm;
	logic [WID-1:0] second;
	logic           eq;
	logic           ltS;
	logic           ltU;
	logic           testBit;
	fcmpFlags_t     flags;
	logic           fGt;

	// Immediate forms replace b as the second operand
	assign useImm = (instr.opcode == OP_CMPI) | (instr.opcode == OP_CMPUI);
	assign second = useImm ? imm : b;

	intCompare #(.WID(WID)) uInt (
		.x       (a),
		.y       (second),
		.eq      (eq),
		.ltS     (ltS),
		.ltU     (ltU),
		.testBit (testBit)
	);

	// Float compare always works on the two registers
	fpCompare #(.WID(WID)) uFp (
		.a     (a),
		.b     (b),
		.flags (flags)
	);

	// Greater only when ordered and neither less nor equal
	assign fGt = ~flags.unord & ~flags.lt & ~flags.eq;

	// ========================================================================
	// Condition vector
	// ========================================================================

	always_comb
	begin
		result = '0;
		// Signed forms fill all eight integer bits
		if ((instr.opcode == OP_R3 && instr.func == FN_CMP) || instr.opcode == OP_CMPI)
		begin
			result[CB_EQ] = eq;
			result[CB_NE] = ~eq;
			result[CB_LT] = ltS;
			result[CB_LE] = ltS | eq;
			result[CB_GE] = ~ltS;
			result[CB_GT] = ~ltS & ~eq;
			result[CB_BC] = ~testBit;
			result[CB_BS] = testBit;
		end
		// Unsigned forms carry only the four orderings
		else if ((instr.opcode == OP_R3 && instr.func == FN_CMPU) ||
			instr.opcode == OP_CMPUI)
		begin
			result[CB_LT] = ltU;
			result[CB_LE] = ltU | eq;
			result[CB_GE] = ~ltU;
			result[CB_GT] = ~ltU & ~eq;
		end
		else if (instr.opcode == OP_FLT3 && instr.func == FN_FCMP)
		begin
			result[FB_EQ]    = flags.eq;
			result[FB_NE]    = ~flags.eq;
			result[FB_LT]    = flags.lt;
			result[FB_LTU]   = flags.unord | flags.lt;
			result[FB_LE]    = flags.lt | flags.eq;
			result[FB_LEU]   = flags.unord | flags.lt | flags.eq;
			result[FB_GT]    = fGt;
			result[FB_GTU]   = flags.unord | fGt;
			result[FB_GE]    = fGt | flags.eq;
			result[FB_GEU]   = flags.unord | fGt | flags.eq;
			result[FB_OGL]   = ~flags.unord & ~flags.eq;
			result[FB_UGL]   = flags.unord | ~flags.eq;
			result[FB_ORD]   = ~flags.nan;
			result[FB_UNORD] = flags.nan;
		end
	end

endmodule

`default_nettype wire

// ==== cmp/intCompare.sv ====
// Integer compare
// Equality, signed and unsigned less-than, and a bit test of an operand pair
`timescale 1ns/1ps
`default_nettype none

module intCompare
#(
	parameter int WID = 64
)
(
	input  wire logic [WID-1:0] x,
	input  wire logic [WID-1:0] y,
	output logic                eq,
	output logic                ltS,
	output logic                ltU,
	output logic                testBit
);

	// Number of low bits of y that index a bit of x
	localparam int IDX = $clog2(WID);

	logic [IDX-1:0] bitIdx;

	// ========================================================================
	// Relations
	// ========================================================================

	assign eq = x == y;

	// Same magnitude compare, read once with and once without the sign
	assign ltS = $signed(x) < $signed(y);
	assign ltU = x < y;

	// Only the low bits of y take part in the bit test
	assign bitIdx = y[IDX-1:0];

	// The caller derives clear and set from this one bit
	assign testBit = x[bitIdx];

endmodule

`default_nettype wire

// ==== cmp/fpCompare.sv ====
// Floating-point compare
// Classifies two IEEE operands of width WID and orders them
`timescale 1ns/1ps
`default_nettype none

module fpCompare
	import cmpPkg::*;
#(
	parameter int WID = 64
)
(
	input  wire logic [WID-1:0] a,
	input  wire logic [WID-1:0] b,
	output fcmpFlags_t          flags
);

	// Exponent width follows the IEEE half, single, double and quad formats
	localparam int EXP = (WID == 16) ? 5 : (WID == 32) ? 8 : (WID == 64) ? 11 : 15;
	localparam int MAN = WID - 1 - EXP;

	logic           signA;
	logic           signB;
	logic [EXP-1:0] expA;
	logic [EXP-1:0] expB;
	logic [MAN-1:0] manA;
	logic [MAN-1:0] manB;
	logic           nanA;
	logic           nanB;
	logic           snanA;
	logic           snanB;
	logic           infA;
	logic           infB;
	logic           zeroA;
	logic           zeroB;
	logic           magLt;
	logic           magEq;
	logic           unord;
	logic           zeroPair;

	// ========================================================================
	// Operand classification
	// ========================================================================

	assign {signA, expA, manA} = a;
	assign {signB, expB, manB} = b;

	// An all-ones exponent is either infinity or NaN, told apart by the mantissa
	assign nanA = (&expA) & (|manA);
	assign nanB = (&expB) & (|manB);
	assign infA = (&expA) & ~(|manA);
	assign infB = (&expB) & ~(|manB);

	// A NaN with the top mantissa bit clear is the signalling kind
	assign snanA = nanA & ~manA[MAN-1];
	assign snanB = nanB & ~manB[MAN-1];

	assign zeroA = ~(|expA) & ~(|manA);
	assign zeroB = ~(|expB) & ~(|manB);

	// ========================================================================
	// Ordering
	// ========================================================================

	// Exponent and mantissa together order like an unsigned magnitude
	assign magLt = a[WID-2:0] < b[WID-2:0];
	assign magEq = a[WID-2:0] == b[WID-2:0];

	assign unord    = nanA | nanB;
	assign zeroPair = zeroA & zeroB;

	// Two zeros compare equal whatever their signs
	assign flags.eq = ~unord & (zeroPair | ((signA == signB) & magEq));

	// With both negative the larger magnitude is the smaller value
	assign flags.lt = ~unord & ~zeroPair &
		((signA & ~signB) |
		 (~signA & ~signB & magLt) |
		 (signA & signB & ~magLt & ~magEq));

	assign flags.unord    = unord;
	assign flags.bothInf  = infA & infB;
	assign flags.nan      = unord;
	assign flags.snan     = snanA | snanB;
	assign flags.zeroPair = zeroPair;

endmodule

`default_nettype wire

// ==== common/cmpPkg.sv ====
// Compare execution unit shared definitions
// Opcodes, function codes, control structs and condition vector bit positions
`default_nettype none

package cmpPkg;

	// Major opcodes with the size variants folded into one code per class
	typedef enum logic [6:0] {
		OP_BRK   = 7'd0,
		OP_R3    = 7'd2,
		OP_ADDI  = 7'd4,
		OP_CMPI  = 7'd11,
		OP_CMPUI = 7'd12,
		OP_FLT3  = 7'd13,
		OP_NOP   = 7'd127
	} opcode_t;

	// Function codes for the register and float classes
	typedef enum logic [3:0] {
		FN_ADD  = 4'd0,
		FN_CMP  = 4'd3,
		FN_CMPU = 4'd4,
		FN_FCMP = 4'd6
	} func_t;

	// The low 21 bits carry register fields that this unit never looks at
	typedef struct packed {
		opcode_t     opcode;
		func_t       func;
		logic [20:0] rsvd;
	} instr_t;

	typedef logic [5:0] tag_t;

	// Control word that follows the operands down the pipeline
	typedef struct packed {
		instr_t instr;
		tag_t   tag;
	} cmpReq_t;

	// Relations and classes of two floating-point operands
	typedef struct packed {
		logic eq;
		logic lt;
		logic unord;
		logic bothInf;
		logic nan;
		logic snan;
		logic zeroPair;
	} fcmpFlags_t;

	// ========================================================================
	// Condition vector bit positions
	// ========================================================================

	// Integer compares
	localparam int CB_EQ = 0;
	localparam int CB_NE = 1;
	localparam int CB_LT = 2;
	localparam int CB_LE = 3;
	localparam int CB_GE = 4;
	localparam int CB_GT = 5;
	localparam int CB_BC = 6;
	localparam int CB_BS = 7;

	// Float compares where the U forms also hold when unordered
	localparam int FB_EQ    = 0;
	localparam int FB_NE    = 1;
	localparam int FB_LT    = 2;
	localparam int FB_LTU   = 3;
	localparam int FB_LE    = 4;
	localparam int FB_LEU   = 5;
	localparam int FB_GT    = 6;
	localparam int FB_GTU   = 7;
	localparam int FB_GE    = 8;
	localparam int FB_GEU   = 9;
	localparam int FB_OGL   = 10;
	localparam int FB_UGL   = 11;
	localparam int FB_ORD   = 12;
	localparam int FB_UNORD = 13;

endpackage

`default_nettype wire
